// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int wordWidth = 16;
  localparam int regCount = 16;

  typedef logic [wordWidth-1:0] wordT;
  typedef logic [3:0] regIndexT;

  // instruction word is {opcode, t, s, m}, four bits each
  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opOr   = 4'h3,
    opXor  = 4'h4,
    opSlt  = 4'h5,
    opLi   = 4'h6,
    opLw   = 4'h7,
    opSw   = 4'h8,
    opBt   = 4'h9,
    opJr   = 4'hA,
    opInt  = 4'hB,
    opEret = 4'hC,
    opNop  = 4'hD
  } opcodeT;

  typedef enum logic [1:0] {
    memNone  = 2'd0,
    memRead  = 2'd1,
    memWrite = 2'd2
  } memControlT;

  typedef enum logic [2:0] {
    jumpNone    = 3'd0,
    jumpBranchT = 3'd1,
    jumpReg     = 3'd2,
    jumpSoftInt = 3'd3,
    jumpEret    = 3'd4
  } jumpControlT;

  // NOP with all register fields zero
  localparam wordT nopWord = {opNop, 12'h000};

endpackage

`default_nettype wire

// File: verilog/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
  parameter cpuPkg::wordT resetPc = 16'h0000
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire cpuPkg::wordT    rs,
  input  wire                  t,
  input  wire cpuPkg::jumpControlT jumpControl,
  input  wire                  interruptOccurs,
  input  wire cpuPkg::wordT    interruptPC,
  input  wire cpuPkg::wordT    BmemRead,
  output cpuPkg::wordT         IfIR,
  output cpuPkg::wordT         IfPC,
  output cpuPkg::wordT         normalNextPC,
  output cpuPkg::wordT         nextPC,
  output cpuPkg::wordT         Baddr
);

  cpuPkg::wordT incrementedPc;
  cpuPkg::wordT branchOffset;

  assign incrementedPc = IfPC + 16'd1;
  // signed s,m field of BT
  assign branchOffset = {{8{IfIR[7]}}, IfIR[7:0]};

  // jumps resolve while the instruction is still in IfIR
  always_comb begin
    case (jumpControl)
      cpuPkg::jumpBranchT: normalNextPC = t ? incrementedPc + branchOffset : incrementedPc;
      cpuPkg::jumpReg:     normalNextPC = rs;
      default:             normalNextPC = incrementedPc;
    endcase
  end

  // interrupt entry and ERET both take the PC from the interrupt unit
  assign nextPC = (interruptOccurs || jumpControl == cpuPkg::jumpEret) ? interruptPC
                                                                       : normalNextPC;
  assign Baddr = nextPC;

  always_ff @(posedge clk) begin
    if (reset) begin
      // one below resetPc so the first nextPC lands on resetPc
      IfPC <= resetPc - 16'd1;
      IfIR <= cpuPkg::nopWord;
    end else begin
      IfPC <= nextPC;
      IfIR <= BmemRead;
    end
  end

  jumpControlKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(jumpControl));

endmodule

`default_nettype wire

// File: verilog/interruptUnit.sv
`timescale 1ns/1ps
`default_nettype none

module interruptUnit #(
  parameter cpuPkg::wordT vectorBase = 16'h0100
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cpuPkg::wordT     normalNextPC,
  input  wire                   softInt,
  input  wire cpuPkg::regIndexT softIndex,
  input  wire                   eret,
  input  wire                   hwReq,
  input  wire cpuPkg::regIndexT hwIndex,
  output logic                  hwAck,
  output logic                  interruptOccurs,
  output cpuPkg::wordT          interruptPC
);

  typedef enum logic {
    ackIdle,
    ackHigh
  } ackStateT;

  ackStateT ackState;
  logic inService;
  logic softTake;
  logic hwTake;
  cpuPkg::regIndexT takenIndex;
  cpuPkg::wordT savedPc;

  assign softTake = softInt && !inService;
  // a software INT in the same cycle wins and the request stays pending
  assign hwTake = hwReq && ackState == ackIdle && !inService && !softInt;
  assign interruptOccurs = softTake || hwTake;

  assign takenIndex = softTake ? softIndex : hwIndex;
  // entry vector is base plus index times 16 and ERET gets the saved PC
  assign interruptPC = interruptOccurs ? vectorBase + {8'h00, takenIndex, 4'h0} : savedPc;

  // four-phase handshake with ack one edge behind req
  always_ff @(posedge clk) begin
    if (reset) begin
      ackState <= ackIdle;
    end else begin
      case (ackState)
        ackIdle: if (hwTake) ackState <= ackHigh;
        ackHigh: if (!hwReq) ackState <= ackIdle;
        default: ackState <= ackIdle;
      endcase
    end
  end

  assign hwAck = ackState == ackHigh;

  always_ff @(posedge clk) begin
    if (reset) begin
      inService <= 1'b0;
    end else if (interruptOccurs) begin
      inService <= 1'b1;
    end else if (eret) begin
      inService <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (interruptOccurs) begin
      savedPc <= normalNextPC;
    end
  end

  // an entry puts the unit in service and blocks the next cycle
  noNestedEntry: assert property (@(posedge clk) disable iff (reset)
    interruptOccurs |=> inService && !interruptOccurs);

  ackAfterReq: assert property (@(posedge clk) disable iff (reset)
    $rose(hwAck) |-> hwReq);

endmodule

`default_nettype wire

// File: verilog/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
  input  wire cpuPkg::wordT     IfIR,
  output cpuPkg::regIndexT      registerS,
  output cpuPkg::regIndexT      registerM,
  output cpuPkg::regIndexT      IdRegisterT,
  output logic                  IdWriteEnable,
  output cpuPkg::jumpControlT   jumpControl,
  output logic                  softInt,
  output cpuPkg::regIndexT      softIndex,
  output logic                  eret
);

  cpuPkg::opcodeT opcode;

  assign opcode = cpuPkg::opcodeT'(IfIR[15:12]);

  // fixed field positions for every class
  assign IdRegisterT = IfIR[11:8];
  // SW keeps the store value in s and the address in m
  assign registerS = IfIR[7:4];
  assign registerM = IfIR[3:0];

  // INT carries its index in m
  assign softIndex = IfIR[3:0];

  always_comb begin
    IdWriteEnable = 1'b0;
    jumpControl = cpuPkg::jumpNone;
    case (opcode)
      cpuPkg::opAdd,
      cpuPkg::opSub,
      cpuPkg::opAnd,
      cpuPkg::opOr,
      cpuPkg::opXor,
      cpuPkg::opLi,
      cpuPkg::opLw: begin
        IdWriteEnable = 1'b1;
      end
      cpuPkg::opBt: begin
        jumpControl = cpuPkg::jumpBranchT;
      end
      cpuPkg::opJr: begin
        jumpControl = cpuPkg::jumpReg;
      end
      cpuPkg::opInt: begin
        jumpControl = cpuPkg::jumpSoftInt;
      end
      cpuPkg::opEret: begin
        jumpControl = cpuPkg::jumpEret;
      end
      // SLT, SW, NOP and unused codes write no register
      default: begin
        IdWriteEnable = 1'b0;
      end
    endcase
  end

  assign softInt = opcode == cpuPkg::opInt;
  assign eret = opcode == cpuPkg::opEret;

endmodule

`default_nettype wire

// File: verilog/operandBypass.sv
`timescale 1ns/1ps
`default_nettype none

module operandBypass (
  input  wire cpuPkg::regIndexT sourceIndex,
  input  wire cpuPkg::wordT     originValue,
  input  wire cpuPkg::regIndexT ExRegisterT,
  input  wire                   ExWriteEnable,
  input  wire cpuPkg::wordT     ExCalResult,
  input  wire cpuPkg::regIndexT MeRegisterT,
  input  wire                   MeWriteEnable,
  input  wire cpuPkg::wordT     MeCalResult,
  output cpuPkg::wordT          sourceValue
);

  logic exHit;
  logic meHit;

  assign exHit = ExWriteEnable && ExRegisterT == sourceIndex;
  assign meHit = MeWriteEnable && MeRegisterT == sourceIndex;

  // newest value first: execute, then memory, then the register file
  always_comb begin
    if (exHit) begin
      sourceValue = ExCalResult;
    end else if (meHit) begin
      sourceValue = MeCalResult;
    end else begin
      sourceValue = originValue;
    end
  end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cpuPkg::regIndexT registerS,
  input  wire cpuPkg::regIndexT registerM,
  input  wire                   tWriteEnable,
  input  wire                   tToWrite,
  input  wire cpuPkg::regIndexT MeRegisterT,
  input  wire                   MeWriteEnable,
  input  wire cpuPkg::wordT     MeCalResult,
  output cpuPkg::wordT          originValueS,
  output cpuPkg::wordT          originValueM,
  output logic                  t,
  output logic [cpuPkg::regCount*cpuPkg::wordWidth-1:0] registerValue
);

  cpuPkg::wordT regs [cpuPkg::regCount];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpuPkg::regCount; i++) begin
        regs[i] <= '0;
      end
      t <= 1'b0;
    end else begin
      if (MeWriteEnable) begin
        regs[MeRegisterT] <= MeCalResult;
      end
      // T updates from execute, one cycle ahead of register writeback
      if (tWriteEnable) begin
        t <= tToWrite;
      end
    end
  end

  // same-cycle writes reach decode through the bypass
  assign originValueS = regs[registerS];
  assign originValueM = regs[registerM];

  for (genvar i = 0; i < cpuPkg::regCount; i++) begin : gDump
    assign registerValue[i*cpuPkg::wordWidth +: cpuPkg::wordWidth] = regs[i];
  end

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cpuPkg::wordT     IfIR,
  input  wire cpuPkg::regIndexT IdRegisterT,
  input  wire                   IdWriteEnable,
  input  wire cpuPkg::wordT     rs,
  input  wire cpuPkg::wordT     rm,
  output cpuPkg::regIndexT      ExRegisterT,
  output logic                  ExWriteEnable,
  output cpuPkg::wordT          ExCalResult,
  output cpuPkg::wordT          ExAaddr,
  output cpuPkg::wordT          ExStoreData,
  output cpuPkg::memControlT    ExMemControl,
  output logic                  tWriteEnable,
  output logic                  tToWrite
);

  cpuPkg::wordT exIr;
  cpuPkg::wordT exRs;
  cpuPkg::wordT exRm;
  cpuPkg::opcodeT exOpcode;

  always_ff @(posedge clk) begin
    if (reset) begin
      exIr <= cpuPkg::nopWord;
      ExRegisterT <= '0;
      ExWriteEnable <= 1'b0;
    end else begin
      exIr <= IfIR;
      ExRegisterT <= IdRegisterT;
      ExWriteEnable <= IdWriteEnable;
    end
  end

  // operands already carry the bypassed values
  always_ff @(posedge clk) begin
    exRs <= rs;
    exRm <= rm;
  end

  assign exOpcode = cpuPkg::opcodeT'(exIr[15:12]);

  always_comb begin
    case (exOpcode)
      cpuPkg::opAdd: ExCalResult = exRs + exRm;
      cpuPkg::opSub: ExCalResult = exRs - exRm;
      cpuPkg::opAnd: ExCalResult = exRs & exRm;
      cpuPkg::opOr:  ExCalResult = exRs | exRm;
      cpuPkg::opXor: ExCalResult = exRs ^ exRm;
      // zero-extended s,m field
      cpuPkg::opLi:  ExCalResult = {8'h00, exIr[7:0]};
      default:       ExCalResult = '0;
    endcase
  end

  // address is rm for both LW and SW
  assign ExAaddr = exRm;
  assign ExStoreData = exRs;

  always_comb begin
    case (exOpcode)
      cpuPkg::opLw: ExMemControl = cpuPkg::memRead;
      cpuPkg::opSw: ExMemControl = cpuPkg::memWrite;
      default:      ExMemControl = cpuPkg::memNone;
    endcase
  end

  assign tWriteEnable = exOpcode == cpuPkg::opSlt;
  assign tToWrite = $signed(exRs) < $signed(exRm);

endmodule

`default_nettype wire

// File: verilog/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
  input  wire                     clk,
  input  wire                     reset,
  input  wire cpuPkg::regIndexT   ExRegisterT,
  input  wire                     ExWriteEnable,
  input  wire cpuPkg::wordT       ExCalResult,
  input  wire cpuPkg::wordT       ExAaddr,
  input  wire cpuPkg::wordT       ExStoreData,
  input  wire cpuPkg::memControlT ExMemControl,
  input  wire cpuPkg::wordT       AmemRead,
  output cpuPkg::regIndexT        MeRegisterT,
  output logic                    MeWriteEnable,
  output cpuPkg::wordT            MeCalResult,
  output cpuPkg::wordT            MeAaddr,
  output cpuPkg::wordT            MeMemResult,
  output cpuPkg::memControlT      MeMemControl
);

  cpuPkg::wordT meAluResult;

  always_ff @(posedge clk) begin
    if (reset) begin
      MeRegisterT <= '0;
      MeWriteEnable <= 1'b0;
      MeMemControl <= cpuPkg::memNone;
    end else begin
      MeRegisterT <= ExRegisterT;
      MeWriteEnable <= ExWriteEnable;
      MeMemControl <= ExMemControl;
    end
  end

  always_ff @(posedge clk) begin
    meAluResult <= ExCalResult;
    MeAaddr <= ExAaddr;
    MeMemResult <= ExStoreData;
  end

  // port A answers in the same cycle
  assign MeCalResult = (MeMemControl == cpuPkg::memRead) ? AmemRead : meAluResult;

  // a store never also writes a register
  storeNoWriteback: assert property (@(posedge clk) disable iff (reset)
    MeMemControl == cpuPkg::memWrite |-> !MeWriteEnable);

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter cpuPkg::wordT resetPc = 16'h0000,
  parameter cpuPkg::wordT vectorBase = 16'h0100
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cpuPkg::wordT     AmemRead,
  input  wire cpuPkg::wordT     BmemRead,
  input  wire                   hwReq,
  input  wire cpuPkg::regIndexT hwIndex,
  output logic                  hwAck,
  output cpuPkg::wordT          MeAaddr,
  output cpuPkg::wordT          Baddr,
  output cpuPkg::wordT          MeMemResult,
  output cpuPkg::memControlT    MeMemControl,
  output logic [cpuPkg::regCount*cpuPkg::wordWidth-1:0] registerValue,
  output cpuPkg::wordT          nextPC
);

  // fetch and interrupt
  cpuPkg::wordT IfIR;
  cpuPkg::wordT normalNextPC;
  cpuPkg::wordT interruptPC;
  logic interruptOccurs;

  // decode
  cpuPkg::regIndexT registerS;
  cpuPkg::regIndexT registerM;
  cpuPkg::regIndexT IdRegisterT;
  logic IdWriteEnable;
  cpuPkg::jumpControlT jumpControl;
  logic softInt;
  cpuPkg::regIndexT softIndex;
  logic eret;
  cpuPkg::wordT originValueS;
  cpuPkg::wordT originValueM;
  cpuPkg::wordT rs;
  cpuPkg::wordT rm;
  logic t;

  // execute and memory
  cpuPkg::regIndexT ExRegisterT;
  logic ExWriteEnable;
  cpuPkg::wordT ExCalResult;
  cpuPkg::wordT ExAaddr;
  cpuPkg::wordT ExStoreData;
  cpuPkg::memControlT ExMemControl;
  logic tWriteEnable;
  logic tToWrite;
  cpuPkg::regIndexT MeRegisterT;
  logic MeWriteEnable;
  cpuPkg::wordT MeCalResult;

  fetchUnit #(.resetPc(resetPc)) u_fetchUnit (
    .clk(clk), .reset(reset), .rs(rs), .t(t), .jumpControl(jumpControl),
    .interruptOccurs(interruptOccurs), .interruptPC(interruptPC), .BmemRead(BmemRead),
    .IfIR(IfIR), .IfPC(), .normalNextPC(normalNextPC), .nextPC(nextPC), .Baddr(Baddr)
  );

  interruptUnit #(.vectorBase(vectorBase)) u_interruptUnit (
    .clk(clk), .reset(reset), .normalNextPC(normalNextPC), .softInt(softInt),
    .softIndex(softIndex), .eret(eret), .hwReq(hwReq), .hwIndex(hwIndex),
    .hwAck(hwAck), .interruptOccurs(interruptOccurs), .interruptPC(interruptPC)
  );

  instructionDecoder u_instructionDecoder (
    .IfIR(IfIR), .registerS(registerS), .registerM(registerM),
    .IdRegisterT(IdRegisterT), .IdWriteEnable(IdWriteEnable), .jumpControl(jumpControl),
    .softInt(softInt), .softIndex(softIndex), .eret(eret)
  );

  operandBypass u_bypassS (
    .sourceIndex(registerS), .originValue(originValueS),
    .ExRegisterT(ExRegisterT), .ExWriteEnable(ExWriteEnable), .ExCalResult(ExCalResult),
    .MeRegisterT(MeRegisterT), .MeWriteEnable(MeWriteEnable), .MeCalResult(MeCalResult),
    .sourceValue(rs)
  );

  operandBypass u_bypassM (
    .sourceIndex(registerM), .originValue(originValueM),
    .ExRegisterT(ExRegisterT), .ExWriteEnable(ExWriteEnable), .ExCalResult(ExCalResult),
    .MeRegisterT(MeRegisterT), .MeWriteEnable(MeWriteEnable), .MeCalResult(MeCalResult),
    .sourceValue(rm)
  );

  registerFile u_registerFile (
    .clk(clk), .reset(reset), .registerS(registerS), .registerM(registerM),
    .tWriteEnable(tWriteEnable), .tToWrite(tToWrite), .MeRegisterT(MeRegisterT),
    .MeWriteEnable(MeWriteEnable), .MeCalResult(MeCalResult),
    .originValueS(originValueS), .originValueM(originValueM), .t(t),
    .registerValue(registerValue)
  );

  executeStage u_executeStage (
    .clk(clk), .reset(reset), .IfIR(IfIR), .IdRegisterT(IdRegisterT),
    .IdWriteEnable(IdWriteEnable), .rs(rs), .rm(rm),
    .ExRegisterT(ExRegisterT), .ExWriteEnable(ExWriteEnable), .ExCalResult(ExCalResult),
    .ExAaddr(ExAaddr), .ExStoreData(ExStoreData), .ExMemControl(ExMemControl),
    .tWriteEnable(tWriteEnable), .tToWrite(tToWrite)
  );

  memoryStage u_memoryStage (
    .clk(clk), .reset(reset), .ExRegisterT(ExRegisterT), .ExWriteEnable(ExWriteEnable),
    .ExCalResult(ExCalResult), .ExAaddr(ExAaddr), .ExStoreData(ExStoreData),
    .ExMemControl(ExMemControl), .AmemRead(AmemRead),
    .MeRegisterT(MeRegisterT), .MeWriteEnable(MeWriteEnable), .MeCalResult(MeCalResult),
    .MeAaddr(MeAaddr), .MeMemResult(MeMemResult), .MeMemControl(MeMemControl)
  );

endmodule

`default_nettype wire

// File: testbench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam cpuPkg::wordT resetPc = 16'h0000;
  localparam cpuPkg::wordT vectorBase = 16'h0100;
  localparam int clockPeriod = 20;
  localparam int driveDelay = 2;
  localparam int ackLimit = 8;

  logic clk;
  logic reset;
  cpuPkg::wordT AmemRead;
  cpuPkg::wordT BmemRead;
  logic hwReq;
  cpuPkg::regIndexT hwIndex;
  logic hwAck;
  cpuPkg::wordT MeAaddr;
  cpuPkg::wordT Baddr;
  cpuPkg::wordT MeMemResult;
  cpuPkg::memControlT MeMemControl;
  logic [cpuPkg::regCount*cpuPkg::wordWidth-1:0] registerValue;
  cpuPkg::wordT nextPC;

  cpuPkg::wordT instMem [0:65535];
  cpuPkg::wordT dataMem [0:65535];

  // case file records tagged with their test number
  logic [8*24-1:0] testNames [$];
  int testCycles [$];
  int progTest [$];
  cpuPkg::wordT progAddr [$];
  cpuPkg::wordT progWord [$];
  int hwEventTest [$];
  int hwEventCycle [$];
  cpuPkg::regIndexT hwEventIndex [$];
  int expTest [$];
  logic expIsReg [$];
  int expAddr [$];
  cpuPkg::wordT expValue [$];

  int cycleNum;
  int errorCount;
  int checkCount;
  int failedTests;
  int watchdogCycles;

  cpu #(.resetPc(resetPc), .vectorBase(vectorBase)) u_cpu (
    .clk(clk), .reset(reset), .AmemRead(AmemRead), .BmemRead(BmemRead),
    .hwReq(hwReq), .hwIndex(hwIndex), .hwAck(hwAck), .MeAaddr(MeAaddr), .Baddr(Baddr),
    .MeMemResult(MeMemResult), .MeMemControl(MeMemControl),
    .registerValue(registerValue), .nextPC(nextPC)
  );

  // both ports answer in the same cycle
  assign BmemRead = instMem[Baddr];
  assign AmemRead = dataMem[MeAaddr];

  always @(posedge clk) begin
    if (!reset && MeMemControl == cpuPkg::memWrite) begin
      dataMem[MeAaddr] <= MeMemResult;
    end
  end

  initial begin
    clk = 1'b0;
    forever begin
      #(clockPeriod / 2) clk = ~clk;
    end
  end

  task automatic compareWord(input string name, input cpuPkg::wordT expected,
                             input cpuPkg::wordT actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0d ns: %0s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compareAck(input string name, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0d ns: %0s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic readCases();
    int fd;
    int code;
    int count;
    int cycles;
    cpuPkg::wordT addr;
    cpuPkg::wordT value;
    cpuPkg::regIndexT index;
    logic [8*16-1:0] keyword;
    logic [8*24-1:0] name;
    logic [8*120-1:0] lineText;
    fd = $fopen("testbench/cpuCases.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/cpuCases.txt");
      errorCount++;
    end else begin
      while ($fscanf(fd, "%s", keyword) == 1) begin
        case (keyword)
          "#": code = $fgets(lineText, fd);
          "test": begin
            code = $fscanf(fd, "%s %d", name, cycles);
            testNames.push_back(name);
            testCycles.push_back(cycles);
          end
          "prog": begin
            code = $fscanf(fd, "%h %d", addr, count);
            for (int k = 0; k < count; k++) begin
              code = $fscanf(fd, "%h", value);
              progTest.push_back(testNames.size() - 1);
              progAddr.push_back(addr);
              progWord.push_back(value);
              addr++;
            end
          end
          "hwint": begin
            code = $fscanf(fd, "%d %h", cycles, index);
            hwEventTest.push_back(testNames.size() - 1);
            hwEventCycle.push_back(cycles);
            hwEventIndex.push_back(index);
          end
          "regs": begin
            for (int k = 0; k < cpuPkg::regCount; k++) begin
              code = $fscanf(fd, "%h", value);
              expTest.push_back(testNames.size() - 1);
              expIsReg.push_back(1'b1);
              expAddr.push_back(k);
              expValue.push_back(value);
            end
          end
          "mem": begin
            code = $fscanf(fd, "%h %h", addr, value);
            expTest.push_back(testNames.size() - 1);
            expIsReg.push_back(1'b0);
            expAddr.push_back(addr);
            expValue.push_back(value);
          end
          default: begin
            $display("unknown keyword %0s in testbench/cpuCases.txt", keyword);
            errorCount++;
          end
        endcase
      end
      $fclose(fd);
    end
    if (testNames.size() == 0) begin
      $display("no tests found in testbench/cpuCases.txt");
      errorCount++;
    end
  endtask

  task automatic prepareMemories(input int testId);
    for (int a = 0; a < 65536; a++) begin
      instMem[a] = cpuPkg::nopWord;
      dataMem[a] = '0;
    end
    foreach (progTest[i]) begin
      if (progTest[i] == testId) begin
        instMem[progAddr[i]] = progWord[i];
      end
    end
  endtask

  // four-phase req/ack at the cycles listed for this test
  task automatic driveHwEvents(input int testId);
    int waited;
    foreach (hwEventTest[i]) begin
      if (hwEventTest[i] == testId) begin
        while (cycleNum < hwEventCycle[i]) begin
          @(posedge clk);
          #(driveDelay);
        end
        compareAck("hwAck", 1'b0, hwAck);
        hwIndex = hwEventIndex[i];
        hwReq = 1'b1;
        waited = 0;
        while (!hwAck && waited < ackLimit) begin
          @(negedge clk);
          waited++;
        end
        compareAck("hwAck", 1'b1, hwAck);
        @(posedge clk);
        #(driveDelay);
        hwReq = 1'b0;
        // ack still high until the core has seen req low
        @(negedge clk);
        compareAck("hwAck", 1'b1, hwAck);
        waited = 0;
        while (hwAck && waited < ackLimit) begin
          @(negedge clk);
          waited++;
        end
        compareAck("hwAck", 1'b0, hwAck);
      end
    end
  endtask

  task automatic checkResults(input int testId);
    cpuPkg::wordT actual;
    foreach (expTest[i]) begin
      if (expTest[i] == testId) begin
        if (expIsReg[i]) begin
          actual = registerValue[expAddr[i]*cpuPkg::wordWidth +: cpuPkg::wordWidth];
          compareWord($sformatf("registerValue[%0d]", expAddr[i]), expValue[i], actual);
        end else begin
          compareWord($sformatf("dataMem[%0h]", expAddr[i]), expValue[i], dataMem[expAddr[i]]);
        end
      end
    end
  endtask

  task automatic runTest(input int testId);
    int errorsBefore;
    errorsBefore = errorCount;
    @(posedge clk);
    #(driveDelay);
    reset = 1'b1;
    hwReq = 1'b0;
    prepareMemories(testId);
    repeat (8) @(posedge clk);
    #(driveDelay);
    // fetch address sits on the reset PC while reset is held
    compareWord("nextPC", resetPc, nextPC);
    reset = 1'b0;
    cycleNum = 0;
    fork
      begin
        repeat (testCycles[testId]) begin
          @(posedge clk);
          cycleNum++;
        end
      end
      driveHwEvents(testId);
    join
    @(negedge clk);
    checkResults(testId);
    if (errorCount == errorsBefore) begin
      $display("test %0d %0s: ok", testId, testNames[testId]);
    end else begin
      failedTests++;
      $display("test %0d %0s: %0d errors", testId, testNames[testId],
               errorCount - errorsBefore);
    end
  endtask

  initial begin
    int total;
    reset = 1'b1;
    hwReq = 1'b0;
    hwIndex = '0;
    errorCount = 0;
    checkCount = 0;
    failedTests = 0;
    cycleNum = 0;
    watchdogCycles = 0;
    prepareMemories(-1);
    readCases();
    total = 100;
    foreach (testCycles[i]) begin
      total += testCycles[i];
    end
    watchdogCycles = total;
    foreach (testNames[i]) begin
      runTest(i);
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testNames.size(), failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (watchdogCycles > 0);
    #(watchdogCycles * clockPeriod);
    $display("run did not finish within %0d cycles", watchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/interruptUnit.sv
verilog/instructionDecoder.sv
verilog/operandBypass.sv
verilog/registerFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpu.sv
testbench/cpuTb.sv

// File: testbench/cpuCases.txt
# test <name> <cycles>; prog <hex addr> <count> <hex words>; hwint <cycle> <hex index>
# regs <r0 .. r15 in hex>; mem <hex addr> <hex value>; vectors at 0100 + index * 10 hex
# dependent ALU chain through both bypass levels
test alu_bypass 16
prog 0000 9 6112 6234 0312 1431 4543 2654 3761 1812 0888
regs 0000 0012 0034 0046 0034 0072 0030 0032 ffbc 0000 0000 0000 0000 0000 0000 0000
# stores, then loads with one instruction gap before use
test load_store 20
prog 0000 12 6140 62a5 8021 6341 0422 8043 7501 d000 0655 7703 d000 4872
regs 0000 0040 00a5 0041 014a 00a5 014a 014a 01ef 0000 0000 0000 0000 0000 0000 0000
mem 0040 00a5
mem 0041 014a
# SLT and BT taken and not taken, JR, signed compare
test branch_jump 28
prog 0000 12 6105 6209 5012 d000 9002 63ee 64ee 6511 5021 d000 9001 6622
prog 000c 11 6710 a070 68ee 69ee 6a33 1b01 50b1 d000 9001 6cee 6d44
regs 0000 0005 0009 0000 0000 0011 0022 0010 0000 0000 0033 fffb 0000 0044 0000 0000
# INT 2 goes to 0120, a wrong vector would mark r13
test soft_int 20
prog 0000 4 6107 b002 6208 0312
prog 0100 2 6dbd c000
prog 0120 2 6e5a c000
regs 0000 0007 0008 000f 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 005a 0000
# request index 3 while the ADD at 0003 sits in fetch
test hw_int 24
prog 0000 8 6103 6204 0312 0433 1541 4652 0763 3871
prog 0130 3 6fc3 d000 c000
hwint 4 3
regs 0000 0003 0004 0007 000e 000b 000f 0016 0017 0000 0000 0000 0000 0000 0000 00c3
